/* alu1/alu1.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module alu1 (
  exec_if.alu bus
);
  import alu_pkg::*;

  alu_op_e             op;
  op_size_e            size;
  op_size_e            step_size;
  logic [`EXEC_DW-1:0] sr1;
  logic [`EXEC_DW-1:0] sr2;
  logic [`EXEC_DW-1:0] eax;
  logic                cf_in;
  logic                af_in;
  logic                df_in;

  logic [`SHAMT_W-1:0] shamt;
  logic [`EXEC_DW:0]   sal_wide;
  logic [`EXEC_DW:0]   sar_wide;
  logic                shift_cf;
  logic [`EXEC_DW-1:0] grp0_res;
  logic [`EXEC_DW-1:0] grp1_res;
  logic [`EXEC_DW-1:0] grp2_res;
  logic [`EXEC_DW-1:0] grp3_res;
  logic [`EXEC_DW-1:0] res;

  logic [`EXEC_DW-1:0] inc_sum;
  logic [`EXEC_DW-1:0] add_sum;
  logic [`EXEC_DW-1:0] cmp_diff;
  logic [`EXEC_DW-1:0] step;
  logic [`EXEC_DW-1:0] ptr_sum;

  logic [7:0]          al;
  logic                lo_adj;
  logic                hi_adj;
  logic [7:0]          new_al;
  flags_t              daa_flags;

  logic [`EXEC_DW-1:0] fa;
  logic [`EXEC_DW-1:0] fb;
  logic [`EXEC_DW-1:0] fsum;
  flags_t              gen_flags;

  assign op        = bus.op.op;
  assign size      = bus.op.size;
  assign step_size = bus.op.step_size;
  assign sr1       = bus.op.sr1;
  assign sr2       = bus.op.sr2;
  assign eax       = bus.op.eax;
  assign cf_in     = bus.op.cf_in;
  assign af_in     = bus.op.af_in;
  assign df_in     = bus.op.df_in;

  // Extra bit on each side catches the last bit shifted out
  assign shamt    = sr2[`SHAMT_W-1:0];
  assign sal_wide = {1'b0, sr1} << shamt;
  assign sar_wide = $signed({sr1, 1'b0}) >>> shamt;
  assign shift_cf = op[0] ? sar_wide[0] : sal_wide[`EXEC_DW];

  always_comb begin
    case (op[1:0])
      2'd0:    grp0_res = sr1 | sr2;
      2'd1:    grp0_res = sr1 & sr2;
      2'd2:    grp0_res = sal_wide[`EXEC_DW-1:0];
      default: grp0_res = sar_wide[`EXEC_DW:1];
    endcase
  end

  always_comb begin
    case (op[1:0])
      2'd0:    grp1_res = sr1;
      2'd1:    grp1_res = sr2;
      2'd2:    grp1_res = '0;
      default: grp1_res = ~sr1;
    endcase
  end

  assign inc_sum  = sr1 + `EXEC_DW'd1;
  assign add_sum  = sr1 + sr2;
  assign cmp_diff = eax - sr1;

  // String pointer moves by the element size
  always_comb begin
    case (step_size)
      SZ_BYTE:  step = `EXEC_DW'd1;
      SZ_WORD:  step = `EXEC_DW'd2;
      SZ_DWORD: step = `EXEC_DW'd4;
      default:  step = `EXEC_DW'd8;
    endcase
    ptr_sum = df_in ? sr1 - step : sr1 + step;
  end

  always_comb begin
    case (op[1:0])
      2'd0:    grp2_res = inc_sum;
      2'd1:    grp2_res = add_sum;
      2'd2:    grp2_res = ptr_sum;
      default: grp2_res = sr1;
    endcase
  end

  // DAA on AL
  assign al        = eax[7:0];
  assign lo_adj    = (al[3:0] > 4'h9) | af_in;
  assign hi_adj    = (al > 8'h99) | cf_in;
  assign new_al    = al + {(hi_adj ? 4'h6 : 4'h0), (lo_adj ? 4'h6 : 4'h0)};
  assign grp3_res  = (op[1:0] == 2'd0) ? {eax[`EXEC_DW-1:8], new_al} : '0;

  always_comb begin
    daa_flags             = '0;
    daa_flags[`FLAG_CF]   = hi_adj;
    daa_flags[`FLAG_AF]   = lo_adj;
    daa_flags[`FLAG_ZF]   = ~|new_al;
    daa_flags[`FLAG_PF]   = ~^new_al;
    daa_flags[`FLAG_SF]   = new_al[7];
  end

  always_comb begin
    case (op[3:2])
      2'd0:    res = grp0_res;
      2'd1:    res = grp1_res;
      2'd2:    res = grp2_res;
      default: res = grp3_res;
    endcase
  end

  // Operands for the flag generator
  always_comb begin
    case (op)
      OP_INC: begin
        fa   = sr1;
        fb   = `EXEC_DW'd1;
        fsum = inc_sum;
      end
      OP_ADD: begin
        fa   = sr1;
        fb   = sr2;
        fsum = add_sum;
      end
      OP_CMP_ACC: begin
        fa   = eax;
        fb   = ~sr1;
        fsum = cmp_diff;
      end
      default: begin
        fa   = sr1;
        fb   = sr2;
        fsum = res;
      end
    endcase
  end

  alu_flags u_flags (
    .size     (size),
    .a        (fa),
    .b        (fb),
    .sum      (fsum),
    .shift_cf (shift_cf),
    .kind     (op),
    .cf_in    (cf_in),
    .sr1      (sr1),
    .flags    (gen_flags)
  );

  assign bus.result = res;
  assign bus.flags  = (op == OP_DAA) ? daa_flags : gen_flags;

endmodule

/* alu1/alu_flags.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module alu_flags (
  input  alu_pkg::op_size_e   size,
  input  logic [`EXEC_DW-1:0] a,
  input  logic [`EXEC_DW-1:0] b,
  input  logic [`EXEC_DW-1:0] sum,
  input  logic                shift_cf,
  input  alu_pkg::alu_op_e    kind,
  input  logic                cf_in,
  input  logic [`EXEC_DW-1:0] sr1,
  output alu_pkg::flags_t     flags
);
  import alu_pkg::*;

  logic a_msb;
  logic b_msb;
  logic s_msb;
  logic zero;
  logic carry_out;
  logic half_carry;
  logic ovf;
  logic parity;

  // Top bits and zero test at the operand width
  always_comb begin
    case (size)
      SZ_BYTE: begin
        a_msb = a[7];
        b_msb = b[7];
        s_msb = sum[7];
        zero  = ~|sum[7:0];
      end
      SZ_WORD: begin
        a_msb = a[15];
        b_msb = b[15];
        s_msb = sum[15];
        zero  = ~|sum[15:0];
      end
      default: begin
        a_msb = a[`EXEC_DW-1];
        b_msb = b[`EXEC_DW-1];
        s_msb = sum[`EXEC_DW-1];
        zero  = ~|sum;
      end
    endcase
  end

  // Carry into a bit is a ^ b ^ sum at that bit
  assign carry_out  = (a_msb & b_msb) | ((a_msb ^ b_msb) & ~s_msb);
  assign half_carry = a[4] ^ b[4] ^ sum[4];
  assign ovf        = (a_msb == b_msb) && (s_msb != a_msb);
  assign parity     = ~^sum[7:0];

  always_comb begin
    flags = '0;
    case (kind)
      OP_OR, OP_AND, OP_NOT, OP_SAL, OP_SAR, OP_ADD, OP_INC, OP_CMP_ACC: begin
        flags[`FLAG_ZF] = zero;
        flags[`FLAG_SF] = s_msb;
        flags[`FLAG_PF] = parity;
      end
      default: flags = '0;
    endcase
    case (kind)
      OP_SAL: begin
        flags[`FLAG_CF] = shift_cf;
        flags[`FLAG_OF] = s_msb ^ shift_cf;
      end
      OP_SAR: flags[`FLAG_CF] = shift_cf;
      OP_ADD: begin
        flags[`FLAG_CF] = carry_out;
        flags[`FLAG_AF] = half_carry;
        flags[`FLAG_OF] = ovf;
      end
      OP_INC: begin
        flags[`FLAG_CF] = cf_in;
        flags[`FLAG_AF] = half_carry;
        flags[`FLAG_OF] = ovf;
      end
      // Subtract via a + ~b + 1, so carries are inverted borrows
      OP_CMP_ACC: begin
        flags[`FLAG_CF] = ~carry_out;
        flags[`FLAG_AF] = ~half_carry;
        flags[`FLAG_OF] = ovf;
      end
      OP_PASS_SR1: begin
        flags[`FLAG_CF] = sr1[0];
        flags[`FLAG_PF] = sr1[2];
        flags[`FLAG_AF] = sr1[4];
        flags[`FLAG_ZF] = sr1[6];
        flags[`FLAG_SF] = sr1[7];
        flags[`FLAG_OF] = sr1[11];
      end
      default: ;
    endcase
  end

endmodule

/* common/alu_pkg.sv */
`include "exec_macros.svh"

package alu_pkg;

  // Upper two bits select the group, lower two the member
  typedef enum logic [3:0] {
    OP_OR       = 4'h0,
    OP_AND      = 4'h1,
    OP_SAL      = 4'h2,
    OP_SAR      = 4'h3,
    OP_PASS_SR1 = 4'h4,
    OP_PASS_SR2 = 4'h5,
    OP_ZERO     = 4'h6,
    OP_NOT      = 4'h7,
    OP_INC      = 4'h8,
    OP_ADD      = 4'h9,
    OP_PTR_STEP = 4'ha,
    OP_CMP_ACC  = 4'hb,
    OP_DAA      = 4'hc
  } alu_op_e;

  // Qword only matters as a pointer step
  typedef enum logic [1:0] {
    SZ_BYTE  = 2'd0,
    SZ_WORD  = 2'd1,
    SZ_DWORD = 2'd2,
    SZ_QWORD = 2'd3
  } op_size_e;

  typedef logic [`EXEC_NFLAGS-1:0] flags_t;

endpackage

/* common/exec_if.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

interface exec_if;
  import alu_pkg::*;
  import exec_pkg::*;

  exec_op_t            op;
  logic [`EXEC_DW-1:0] result;
  flags_t              flags;

  // Controller side holds the latched operation
  modport ctrl (
    output op,
    input  result,
    input  flags
  );

  // ALU answers combinationally
  modport alu (
    input  op,
    output result,
    output flags
  );

endinterface

/* common/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Datapath width of the execute stage
`define EXEC_DW 32

// Arithmetic flag vector
`define EXEC_NFLAGS 6

// Bit positions inside the flag vector
`define FLAG_CF 0
`define FLAG_PF 1
`define FLAG_AF 2
`define FLAG_ZF 3
`define FLAG_SF 4
`define FLAG_OF 5

// Shift count taken from the low bits of sr2
`define SHAMT_W 5

`endif

/* common/exec_pkg.sv */
`include "exec_macros.svh"

package exec_pkg;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_ACK  = 2'd2
  } exec_state_e;

  // One operation as captured from the host
  typedef struct packed {
    alu_pkg::alu_op_e    op;
    alu_pkg::op_size_e   size;
    logic [`EXEC_DW-1:0] sr1;
    logic [`EXEC_DW-1:0] sr2;
    logic [`EXEC_DW-1:0] eax;
    alu_pkg::op_size_e   step_size;
    logic                cf_in;
    logic                af_in;
    logic                df_in;
  } exec_op_t;

endpackage

/* rtl/exec_ctrl.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  input  alu_pkg::alu_op_e    op,
  input  alu_pkg::op_size_e   size,
  input  logic [`EXEC_DW-1:0] sr1,
  input  logic [`EXEC_DW-1:0] sr2,
  input  logic [`EXEC_DW-1:0] eax,
  input  alu_pkg::op_size_e   step_size,
  input  logic                cf_in,
  input  logic                af_in,
  input  logic                df_in,
  output logic                ack,
  output logic [`EXEC_DW-1:0] result,
  output alu_pkg::flags_t     flags,
  exec_if.ctrl                bus
);
  import exec_pkg::*;

  exec_state_e state;
  exec_op_t    op_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      result <= '0;
      flags  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_CALC;
          end
        end
        // ALU has settled on the latched operands
        ST_CALC: begin
          result <= bus.result;
          flags  <= bus.flags;
          state  <= ST_ACK;
        end
        ST_ACK: begin
          if (!req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operation capture on acceptance
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      op_q <= '{op: op, size: size, sr1: sr1, sr2: sr2, eax: eax,
                step_size: step_size, cf_in: cf_in, af_in: af_in, df_in: df_in};
    end
  end

  assign bus.op = op_q;
  assign ack    = (state == ST_ACK);

endmodule

/* rtl/exec_top.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  input  alu_pkg::alu_op_e    op,
  input  alu_pkg::op_size_e   size,
  input  logic [`EXEC_DW-1:0] sr1,
  input  logic [`EXEC_DW-1:0] sr2,
  input  logic [`EXEC_DW-1:0] eax,
  input  alu_pkg::op_size_e   step_size,
  input  logic                cf_in,
  input  logic                af_in,
  input  logic                df_in,
  output logic                ack,
  output logic [`EXEC_DW-1:0] result,
  output alu_pkg::flags_t     flags
);

  exec_if u_bus ();

  exec_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .op        (op),
    .size      (size),
    .sr1       (sr1),
    .sr2       (sr2),
    .eax       (eax),
    .step_size (step_size),
    .cf_in     (cf_in),
    .af_in     (af_in),
    .df_in     (df_in),
    .ack       (ack),
    .result    (result),
    .flags     (flags),
    .bus       (u_bus.ctrl)
  );

  alu1 u_alu1 (
    .bus (u_bus.alu)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_exec -f tb.f > build.log 2>&1 ||
  { cat build.log; exit 1; }
./obj_dir/Vtb_exec > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* tb.f */
+incdir+common
common/alu_pkg.sv
common/exec_pkg.sv
common/exec_if.sv
alu1/alu_flags.sv
alu1/alu1.sv
rtl/exec_ctrl.sv
rtl/exec_top.sv
tb/exec_checker.sv
tb/tb_exec.sv

/* tb/exec_checker.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_checker (
  input logic                clk,
  input logic                rst,
  input logic                req,
  input logic                ack,
  input logic [`EXEC_DW-1:0] result
);

  ack_in_reset: assert property (@(posedge clk) rst |=> !ack)
    else $error("ack high after a reset edge");

  // Two edges of req before ack
  ack_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req, 1) && $past(req, 2))
    else $error("ack rose without req held for two edges");

  ack_hold: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
    else $error("ack dropped while req high");

  ack_release: assert property (@(posedge clk) disable iff (rst) ack && !req |=> !ack)
    else $error("ack did not fall after req fell");

  result_hold: assert property (@(posedge clk) disable iff (rst)
    ack |=> !ack || $stable(result))
    else $error("result changed while ack high");

endmodule

bind exec_ctrl exec_checker u_checker (
  .clk    (clk),
  .rst    (rst),
  .req    (req),
  .ack    (ack),
  .result (result)
);

/* tb/tb_exec.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module tb_exec;
  import alu_pkg::*;

  localparam int N_OPS      = 400;
  localparam int MAX_CYCLES = N_OPS * 12 + 100;
  localparam logic [31:0] SEED = 32'h9cb3b9bc;

  logic                clk;
  logic                rst;
  logic                req;
  alu_op_e             op;
  op_size_e            size;
  logic [`EXEC_DW-1:0] sr1;
  logic [`EXEC_DW-1:0] sr2;
  logic [`EXEC_DW-1:0] eax;
  op_size_e            step_size;
  logic                cf_in;
  logic                af_in;
  logic                df_in;
  logic                ack;
  logic [`EXEC_DW-1:0] result;
  flags_t              flags;

  int errors;
  int n_done;
  int cycles;

  exec_top DUT (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .op        (op),
    .size      (size),
    .sr1       (sr1),
    .sr2       (sr2),
    .eax       (eax),
    .step_size (step_size),
    .cf_in     (cf_in),
    .af_in     (af_in),
    .df_in     (df_in),
    .ack       (ack),
    .result    (result),
    .flags     (flags)
  );

  always #4 clk = ~clk;

  task automatic finish_run();
    $display("Operations: %0d, errors: %0d", n_done, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      errors++;
      finish_run();
    end
  end

  task automatic check_word(string name, logic [`EXEC_DW-1:0] got,
                            logic [`EXEC_DW-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h (op %s)", name, got, exp, op.name());
    end
  endtask

  task automatic check_flags(string name, flags_t got, flags_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h (op %s)", name, got, exp, op.name());
    end
  endtask

  // Reference model of the x86 result and flag rules
  task automatic compute_expected(output logic [`EXEC_DW-1:0] res, output flags_t fl);
    int          w;
    int          cnt;
    logic [31:0] mask;
    logic [32:0] wide;
    logic [31:0] fval;
    logic [31:0] step;
    logic        zsp;
    logic [7:0]  al;
    logic        lo;
    logic        hi;
    logic [7:0]  new_al;
    w    = (size == SZ_BYTE) ? 8 : (size == SZ_WORD) ? 16 : 32;
    mask = (w == 32) ? 32'hffff_ffff : ((32'h1 << w) - 32'h1);
    cnt  = int'(sr2[4:0]);
    res  = '0;
    fl   = '0;
    fval = '0;
    zsp  = 1'b0;
    case (op)
      OP_OR, OP_AND, OP_NOT: begin
        res  = (op == OP_OR) ? (sr1 | sr2) : (op == OP_AND) ? (sr1 & sr2) : ~sr1;
        fval = res;
        zsp  = 1'b1;
      end
      OP_SAL: begin
        res  = sr1 << cnt;
        fval = res;
        zsp  = 1'b1;
        if (cnt != 0) fl[`FLAG_CF] = sr1[32 - cnt];
        fl[`FLAG_OF] = res[w-1] ^ fl[`FLAG_CF];
      end
      OP_SAR: begin
        res  = $signed(sr1) >>> cnt;
        fval = res;
        zsp  = 1'b1;
        if (cnt != 0) fl[`FLAG_CF] = sr1[cnt - 1];
      end
      OP_PASS_SR1: begin
        res = sr1;
        fl  = {sr1[11], sr1[7], sr1[6], sr1[4], sr1[2], sr1[0]};
      end
      OP_PASS_SR2: res = sr2;
      OP_INC: begin
        res  = sr1 + 32'd1;
        fval = res;
        zsp  = 1'b1;
        fl[`FLAG_CF] = cf_in;
        fl[`FLAG_AF] = (sr1[3:0] == 4'hf);
        fl[`FLAG_OF] = ~sr1[w-1] & res[w-1];
      end
      OP_ADD: begin
        res  = sr1 + sr2;
        fval = res;
        zsp  = 1'b1;
        wide = {1'b0, sr1 & mask} + {1'b0, sr2 & mask};
        fl[`FLAG_CF] = wide[w];
        fl[`FLAG_AF] = ({1'b0, sr1[3:0]} + {1'b0, sr2[3:0]}) > 5'h0f;
        fl[`FLAG_OF] = (sr1[w-1] == sr2[w-1]) && (res[w-1] != sr1[w-1]);
      end
      OP_PTR_STEP: begin
        step = 32'd1 << step_size;
        res  = df_in ? sr1 - step : sr1 + step;
      end
      OP_CMP_ACC: begin
        res  = sr1;
        fval = eax - sr1;
        zsp  = 1'b1;
        fl[`FLAG_CF] = (eax & mask) < (sr1 & mask);
        fl[`FLAG_AF] = eax[3:0] < sr1[3:0];
        fl[`FLAG_OF] = (eax[w-1] != sr1[w-1]) && (fval[w-1] != eax[w-1]);
      end
      OP_DAA: begin
        al     = eax[7:0];
        lo     = (al[3:0] > 4'h9) || af_in;
        hi     = (al > 8'h99) || cf_in;
        new_al = al + (hi ? 8'h60 : 8'h00) + (lo ? 8'h06 : 8'h00);
        res    = {eax[31:8], new_al};
        fl[`FLAG_CF] = hi;
        fl[`FLAG_AF] = lo;
        fl[`FLAG_ZF] = (new_al == 8'h00);
        fl[`FLAG_SF] = new_al[7];
        fl[`FLAG_PF] = ~^new_al;
      end
      default: ;
    endcase
    if (zsp) begin
      fl[`FLAG_ZF] = ((fval & mask) == 32'h0);
      fl[`FLAG_SF] = fval[w-1];
      fl[`FLAG_PF] = ~^fval[7:0];
    end
  endtask

  // One four-phase transfer, entered 1 ns after a rising edge
  task automatic run_handshake();
    logic [`EXEC_DW-1:0] exp_res;
    flags_t              exp_flags;
    int                  edges;
    int                  hold;
    op        = alu_op_e'(4'($urandom_range(12, 0)));
    size      = op_size_e'(2'($urandom_range(3, 0)));
    step_size = op_size_e'(2'($urandom_range(3, 0)));
    sr1       = $urandom;
    sr2       = $urandom;
    eax       = $urandom;
    cf_in     = 1'($urandom);
    af_in     = 1'($urandom);
    df_in     = 1'($urandom);
    if ($urandom_range(7, 0) == 0) sr2[4:0] = 5'd0;
    compute_expected(exp_res, exp_flags);
    req   = 1'b1;
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack && edges < 8);
    if (!ack) begin
      errors++;
      $display("ack never arrived for op %s", op.name());
    end else if (edges != 2) begin
      errors++;
      $display("ack arrived %0d edges after req instead of two", edges);
    end
    check_word("result", result, exp_res);
    check_flags("flags", flags, exp_flags);
    // Occasionally keep req up after ack
    hold = ($urandom_range(3, 0) == 0) ? $urandom_range(4, 1) : 0;
    repeat (hold) begin
      @(posedge clk);
      #1;
      if (!ack) begin
        errors++;
        $display("ack dropped while req was still high");
      end
      check_word("result", result, exp_res);
      check_flags("flags", flags, exp_flags);
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    if (ack) begin
      errors++;
      $display("ack still high one edge after req fell");
    end
    n_done++;
  endtask

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    rst       = 1'b1;
    req       = 1'b0;
    op        = OP_OR;
    size      = SZ_DWORD;
    sr1       = '0;
    sr2       = '0;
    eax       = '0;
    step_size = SZ_BYTE;
    cf_in     = 1'b0;
    af_in     = 1'b0;
    df_in     = 1'b0;
    errors    = 0;
    n_done    = 0;
    cycles    = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    if (ack !== 1'b0 || result !== '0 || flags !== '0) begin
      errors++;
      $display("Outputs not cleared after reset");
    end
    for (int i = 0; i < N_OPS; i++) begin
      run_handshake();
    end
    finish_run();
  end

endmodule
